/* common/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// data width of every csr
`define CSR_XLEN 32

// machine-mode csr addresses
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID   12'hF12

// mstatus bit positions
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7

// read-only id values
`define MVENDORID_VAL 32'h7973_7978
`define MARCHID_VAL   32'h015f_de77

// cause code for ecall from m-mode
`define CAUSE_ECALL_M 32'd11

// writable bits, anything outside the mask keeps its value
`define MSTATUS_WMASK 32'h0000_0088
`define MTVEC_WMASK   32'hFFFF_FFFC
`define MEPC_WMASK    32'hFFFF_FFFC

`endif

/* common/csr_pkg.sv */
package csr_pkg;

  // op of the retiring instruction
  // immediate forms reuse rw/rs/rc with the immediate in src
  typedef enum logic [2:0] {
    OP_NONE  = 3'd0,
    OP_RW    = 3'd1,
    OP_RS    = 3'd2,
    OP_RC    = 3'd3,
    OP_ECALL = 3'd4,
    OP_MRET  = 3'd5
  } csr_op_e;

  // storage slot inside the register file
  typedef enum logic [1:0] {
    IDX_MSTATUS = 2'd0,
    IDX_MCAUSE  = 2'd1,
    IDX_MEPC    = 2'd2,
    IDX_MTVEC   = 2'd3
  } csr_idx_e;

  // trap-related move of the mstatus interrupt bits
  typedef enum logic [1:0] {
    STAT_NONE        = 2'd0,
    STAT_TRAP_ENTER  = 2'd1,
    STAT_TRAP_RETURN = 2'd2
  } status_upd_e;

endpackage

/* common/csr_wr_if.sv */
`timescale 1ns/10ps
`include "csr_defs.svh"

interface csr_wr_if;

  // port 0, general csr writes and mepc on ecall
  logic                  wen0;
  csr_pkg::csr_idx_e     idx0;
  logic [`CSR_XLEN-1:0]  data0;

  // port 1, only mcause on ecall
  logic                  wen1;
  csr_pkg::csr_idx_e     idx1;
  logic [`CSR_XLEN-1:0]  data1;

  csr_pkg::status_upd_e  status_upd;

  modport ctrl (
    output wen0, idx0, data0, wen1, idx1, data1, status_upd
  );

  modport regfile (
    input wen0, idx0, data0, wen1, idx1, data1, status_upd
  );

endinterface

/* csr/csr_regfile.sv */
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  csr_pkg::csr_idx_e     rd_idx,
  csr_wr_if.regfile             wr,
  output logic [`CSR_XLEN-1:0]  rd_data,
  output logic [`CSR_XLEN-1:0]  mtvec,
  output logic [`CSR_XLEN-1:0]  mepc
);

  // one entry per writable csr, indexed by slot
  logic [`CSR_XLEN-1:0] csr_q [0:3];

  logic mie_q;
  logic mpie_q;

  assign mie_q  = csr_q[csr_pkg::IDX_MSTATUS][`MSTATUS_MIE_BIT];
  assign mpie_q = csr_q[csr_pkg::IDX_MSTATUS][`MSTATUS_MPIE_BIT];

  // combinational read, old value seen in the same cycle
  assign rd_data = csr_q[rd_idx];

  // trap targets straight to the controller
  assign mtvec = csr_q[csr_pkg::IDX_MTVEC];
  assign mepc  = csr_q[csr_pkg::IDX_MEPC];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      csr_q[csr_pkg::IDX_MSTATUS] <= '0;
      csr_q[csr_pkg::IDX_MCAUSE]  <= '0;
      csr_q[csr_pkg::IDX_MEPC]    <= '0;
      csr_q[csr_pkg::IDX_MTVEC]   <= '0;
    end
    else
    begin
      // both ports may fire together, never on the same slot
      if (wr.wen0)
      begin
        csr_q[wr.idx0] <= wr.data0;
      end
      if (wr.wen1)
      begin
        csr_q[wr.idx1] <= wr.data1;
      end

      // mstatus is not written by a port during a trap
      case (wr.status_upd)
        csr_pkg::STAT_TRAP_ENTER:
        begin
          csr_q[csr_pkg::IDX_MSTATUS][`MSTATUS_MPIE_BIT] <= mie_q;
          csr_q[csr_pkg::IDX_MSTATUS][`MSTATUS_MIE_BIT]  <= 1'b0;
        end
        csr_pkg::STAT_TRAP_RETURN:
        begin
          csr_q[csr_pkg::IDX_MSTATUS][`MSTATUS_MIE_BIT]  <= mpie_q;
          csr_q[csr_pkg::IDX_MSTATUS][`MSTATUS_MPIE_BIT] <= 1'b1;
        end
        default:
        begin
          // nothing to move
        end
      endcase
    end
  end

endmodule

/* csr/csr_alu.sv */
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_alu (
  input  csr_pkg::csr_op_e      alu_op,
  input  csr_pkg::csr_idx_e     idx,
  input  logic [`CSR_XLEN-1:0]  old_val,
  input  logic [`CSR_XLEN-1:0]  src,
  output logic [`CSR_XLEN-1:0]  new_val
);

  logic [`CSR_XLEN-1:0] raw_val;
  logic [`CSR_XLEN-1:0] wmask;

  // read-modify-write result before masking
  always_comb
  begin
    case (alu_op)
      csr_pkg::OP_RW: raw_val = src;
      csr_pkg::OP_RS: raw_val = old_val | src;
      csr_pkg::OP_RC: raw_val = old_val & ~src;
      default:        raw_val = old_val;
    endcase
  end

  // writable bits of the target slot
  always_comb
  begin
    case (idx)
      csr_pkg::IDX_MSTATUS: wmask = `MSTATUS_WMASK;
      csr_pkg::IDX_MEPC:    wmask = `MEPC_WMASK;
      csr_pkg::IDX_MTVEC:   wmask = `MTVEC_WMASK;
      // mcause takes every bit
      default:              wmask = '1;
    endcase
  end

  assign new_val = (raw_val & wmask) | (old_val & ~wmask);

endmodule

/* rtl/csr_ctrl.sv */
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_ctrl (
  input  logic                  exu_valid,
  input  csr_pkg::csr_op_e      op,
  input  logic [11:0]           csr_addr,
  input  logic [`CSR_XLEN-1:0]  src,
  input  logic [`CSR_XLEN-1:0]  pc,
  input  logic [`CSR_XLEN-1:0]  rd_data,
  input  logic [`CSR_XLEN-1:0]  mtvec,
  input  logic [`CSR_XLEN-1:0]  mepc,
  input  logic [`CSR_XLEN-1:0]  new_val,
  output csr_pkg::csr_idx_e     rd_idx,
  output csr_pkg::csr_op_e      alu_op,
  output logic [`CSR_XLEN-1:0]  alu_old,
  output logic [`CSR_XLEN-1:0]  alu_src,
  output logic [`CSR_XLEN-1:0]  rdata,
  output logic                  illegal,
  output logic                  redirect,
  output logic [`CSR_XLEN-1:0]  redirect_pc,
  csr_wr_if.ctrl                wr
);

  logic                 is_slot;
  logic                 is_id;
  logic [`CSR_XLEN-1:0] id_val;
  logic                 csr_op;
  logic                 is_ecall;
  logic                 is_mret;
  logic                 csr_legal;

  // address decode, either a storage slot or a read-only id
  always_comb
  begin
    is_slot = 1'b0;
    is_id   = 1'b0;
    id_val  = '0;
    rd_idx  = csr_pkg::IDX_MSTATUS;
    case (csr_addr)
      `CSR_ADDR_MSTATUS:
      begin
        is_slot = 1'b1;
        rd_idx  = csr_pkg::IDX_MSTATUS;
      end
      `CSR_ADDR_MCAUSE:
      begin
        is_slot = 1'b1;
        rd_idx  = csr_pkg::IDX_MCAUSE;
      end
      `CSR_ADDR_MEPC:
      begin
        is_slot = 1'b1;
        rd_idx  = csr_pkg::IDX_MEPC;
      end
      `CSR_ADDR_MTVEC:
      begin
        is_slot = 1'b1;
        rd_idx  = csr_pkg::IDX_MTVEC;
      end
      `CSR_ADDR_MVENDORID:
      begin
        is_id  = 1'b1;
        id_val = `MVENDORID_VAL;
      end
      `CSR_ADDR_MARCHID:
      begin
        is_id  = 1'b1;
        id_val = `MARCHID_VAL;
      end
      default:
      begin
        // unknown address
      end
    endcase
  end

  assign csr_op   = (op == csr_pkg::OP_RW) || (op == csr_pkg::OP_RS) ||
                    (op == csr_pkg::OP_RC);
  assign is_ecall = exu_valid && (op == csr_pkg::OP_ECALL);
  assign is_mret  = exu_valid && (op == csr_pkg::OP_MRET);

  // csrrw to an id register cannot be honoured
  assign illegal   = exu_valid && csr_op &&
                     (!(is_slot || is_id) || (is_id && (op == csr_pkg::OP_RW)));
  assign csr_legal = exu_valid && csr_op && is_slot;

  // old value, zero on unknown address
  assign rdata = is_id ? id_val : (is_slot ? rd_data : '0);

  assign alu_op  = csr_op ? op : csr_pkg::OP_NONE;
  assign alu_old = rd_data;
  assign alu_src = src;

  // ecall takes both ports, mepc on 0 and mcause on 1
  assign wr.wen0  = csr_legal || is_ecall;
  assign wr.idx0  = is_ecall ? csr_pkg::IDX_MEPC : rd_idx;
  assign wr.data0 = is_ecall ? (pc & `MEPC_WMASK) : new_val;
  assign wr.wen1  = is_ecall;
  assign wr.idx1  = csr_pkg::IDX_MCAUSE;
  assign wr.data1 = `CAUSE_ECALL_M;

  always_comb
  begin
    if (is_ecall)
    begin
      wr.status_upd = csr_pkg::STAT_TRAP_ENTER;
    end
    else if (is_mret)
    begin
      wr.status_upd = csr_pkg::STAT_TRAP_RETURN;
    end
    else
    begin
      wr.status_upd = csr_pkg::STAT_NONE;
    end
  end

  assign redirect    = is_ecall || is_mret;
  assign redirect_pc = (op == csr_pkg::OP_MRET) ? mepc : mtvec;

endmodule

/* rtl/csr_unit_top.sv */
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_unit_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  exu_valid,
  input  csr_pkg::csr_op_e      op,
  input  logic [11:0]           csr_addr,
  input  logic [`CSR_XLEN-1:0]  src,
  input  logic [`CSR_XLEN-1:0]  pc,
  output logic [`CSR_XLEN-1:0]  rdata,
  output logic                  illegal,
  output logic                  redirect,
  output logic [`CSR_XLEN-1:0]  redirect_pc
);

  csr_pkg::csr_idx_e    rd_idx;
  csr_pkg::csr_op_e     alu_op;
  logic [`CSR_XLEN-1:0] alu_old;
  logic [`CSR_XLEN-1:0] alu_src;
  logic [`CSR_XLEN-1:0] new_val;
  logic [`CSR_XLEN-1:0] rd_data;
  logic [`CSR_XLEN-1:0] mtvec;
  logic [`CSR_XLEN-1:0] mepc;

  // write path from controller to storage
  csr_wr_if wr_if ();

  csr_ctrl u_ctrl (
    .exu_valid   (exu_valid),
    .op          (op),
    .csr_addr    (csr_addr),
    .src         (src),
    .pc          (pc),
    .rd_data     (rd_data),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .new_val     (new_val),
    .rd_idx      (rd_idx),
    .alu_op      (alu_op),
    .alu_old     (alu_old),
    .alu_src     (alu_src),
    .rdata       (rdata),
    .illegal     (illegal),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .wr          (wr_if.ctrl)
  );

  csr_alu u_alu (
    .alu_op  (alu_op),
    .idx     (rd_idx),
    .old_val (alu_old),
    .src     (alu_src),
    .new_val (new_val)
  );

  csr_regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .wr      (wr_if.regfile),
    .rd_data (rd_data),
    .mtvec   (mtvec),
    .mepc    (mepc)
  );

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int period     = 20,
  parameter int rst_cycles = 8
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(period / 2) clk = ~clk;
    end
  end

  // reset released on a rising edge, seen by the dut one edge later
  initial
  begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* tb/csr_unit_tb.sv */
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_unit_tb;

  localparam int num_instr  = 2000;
  localparam int clk_period = 20;
  localparam int rst_cycles = 8;
  // random run plus reset and the directed reads, with some margin
  localparam int timeout_ns = (num_instr + 20) * clk_period + 2000;

  logic             clk;
  logic             rst;
  logic             exu_valid;
  csr_pkg::csr_op_e op;
  logic [11:0]      csr_addr;
  logic [31:0]      src;
  logic [31:0]      pc;
  logic [31:0]      rdata;
  logic             illegal;
  logic             redirect;
  logic [31:0]      redirect_pc;

  // reference copies of the writable csrs
  logic [31:0] m_mstatus;
  logic [31:0] m_mcause;
  logic [31:0] m_mepc;
  logic [31:0] m_mtvec;

  integer seed;

  tb_clkgen #(
    .period     (clk_period),
    .rst_cycles (rst_cycles)
  ) u_clkgen (
    .clk (clk),
    .rst (rst)
  );

  csr_unit_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .exu_valid   (exu_valid),
    .op          (op),
    .csr_addr    (csr_addr),
    .src         (src),
    .pc          (pc),
    .rdata       (rdata),
    .illegal     (illegal),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  function automatic logic addr_known(input logic [11:0] addr);
    case (addr)
      `CSR_ADDR_MSTATUS, `CSR_ADDR_MCAUSE, `CSR_ADDR_MEPC, `CSR_ADDR_MTVEC,
      `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic addr_read_only(input logic [11:0] addr);
    return (addr == `CSR_ADDR_MVENDORID) || (addr == `CSR_ADDR_MARCHID);
  endfunction

  function automatic logic [31:0] model_value(input logic [11:0] addr);
    case (addr)
      `CSR_ADDR_MSTATUS:   return m_mstatus;
      `CSR_ADDR_MCAUSE:    return m_mcause;
      `CSR_ADDR_MEPC:      return m_mepc;
      `CSR_ADDR_MTVEC:     return m_mtvec;
      `CSR_ADDR_MVENDORID: return `MVENDORID_VAL;
      `CSR_ADDR_MARCHID:   return `MARCHID_VAL;
      default:             return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] writable_mask(input logic [11:0] addr);
    case (addr)
      `CSR_ADDR_MSTATUS: return `MSTATUS_WMASK;
      `CSR_ADDR_MEPC:    return `MEPC_WMASK;
      `CSR_ADDR_MTVEC:   return `MTVEC_WMASK;
      default:           return 32'hFFFF_FFFF;
    endcase
  endfunction

  function automatic logic [11:0] addr_by_index(input int k);
    case (k)
      0:       return `CSR_ADDR_MSTATUS;
      1:       return `CSR_ADDR_MCAUSE;
      2:       return `CSR_ADDR_MEPC;
      3:       return `CSR_ADDR_MTVEC;
      4:       return `CSR_ADDR_MVENDORID;
      default: return `CSR_ADDR_MARCHID;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("Mismatch at %0t ns: %s expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // expected outputs for the instruction now on the inputs
  task automatic check_outputs();
    logic        is_csr_op;
    logic        exp_illegal;
    logic        exp_redirect;
    logic [31:0] exp_pc;
    is_csr_op = exu_valid &&
                (op == csr_pkg::OP_RW || op == csr_pkg::OP_RS || op == csr_pkg::OP_RC);
    exp_illegal = is_csr_op && (!addr_known(csr_addr) ||
                  (op == csr_pkg::OP_RW && addr_read_only(csr_addr)));
    exp_redirect = exu_valid && (op == csr_pkg::OP_ECALL || op == csr_pkg::OP_MRET);
    check_value("illegal", {31'd0, exp_illegal}, {31'd0, illegal});
    check_value("redirect", {31'd0, exp_redirect}, {31'd0, redirect});
    if (exp_redirect)
    begin
      exp_pc = (op == csr_pkg::OP_ECALL) ? m_mtvec : m_mepc;
      check_value("redirect_pc", exp_pc, redirect_pc);
    end
    // old value of the csr, before this instruction
    if (is_csr_op && !exp_illegal)
    begin
      check_value("rdata", model_value(csr_addr), rdata);
    end
  endtask

  // state after the coming rising edge
  task automatic update_model();
    logic [31:0] old_val;
    logic [31:0] raw_val;
    logic [31:0] mask;
    logic [31:0] next_val;
    if (exu_valid)
    begin
      case (op)
        csr_pkg::OP_RW, csr_pkg::OP_RS, csr_pkg::OP_RC:
        begin
          if (addr_known(csr_addr) && !addr_read_only(csr_addr))
          begin
            old_val = model_value(csr_addr);
            if (op == csr_pkg::OP_RW)
              raw_val = src;
            else if (op == csr_pkg::OP_RS)
              raw_val = old_val | src;
            else
              raw_val = old_val & ~src;
            mask     = writable_mask(csr_addr);
            next_val = (raw_val & mask) | (old_val & ~mask);
            case (csr_addr)
              `CSR_ADDR_MSTATUS: m_mstatus = next_val;
              `CSR_ADDR_MCAUSE:  m_mcause  = next_val;
              `CSR_ADDR_MEPC:    m_mepc    = next_val;
              default:           m_mtvec   = next_val;
            endcase
          end
        end
        csr_pkg::OP_ECALL:
        begin
          m_mepc   = pc & ~32'h3;
          m_mcause = `CAUSE_ECALL_M;
          m_mstatus[`MSTATUS_MPIE_BIT] = m_mstatus[`MSTATUS_MIE_BIT];
          m_mstatus[`MSTATUS_MIE_BIT]  = 1'b0;
        end
        csr_pkg::OP_MRET:
        begin
          m_mstatus[`MSTATUS_MIE_BIT]  = m_mstatus[`MSTATUS_MPIE_BIT];
          m_mstatus[`MSTATUS_MPIE_BIT] = 1'b1;
        end
        default:
        begin
        end
      endcase
    end
  endtask

  // called on a rising edge, returns on the next one
  task automatic issue(input logic valid, input csr_pkg::csr_op_e op_in,
                       input logic [11:0] addr_in, input logic [31:0] src_in,
                       input logic [31:0] pc_in);
    exu_valid <= valid;
    op        <= op_in;
    csr_addr  <= addr_in;
    src       <= src_in;
    pc        <= pc_in;
    @(negedge clk);
    check_outputs();
    update_model();
    @(posedge clk);
  endtask

  task automatic issue_random();
    logic [31:0]      rnd;
    logic [31:0]      src_val;
    logic [11:0]      addr_val;
    csr_pkg::csr_op_e op_val;
    int               pick;
    rnd  = $random(seed);
    pick = rnd % 100;
    rnd  = $random(seed);
    // mostly known addresses, now and then a random one
    if (rnd % 10 < 9)
      addr_val = addr_by_index(rnd % 6);
    else
      addr_val = rnd[31:20];
    rnd = $random(seed);
    // small values stand for the immediate forms
    if (rnd % 10 < 3)
      src_val = {27'd0, rnd[4:0]};
    else
      src_val = $random(seed);
    rnd = $random(seed);
    if (pick < 10)
    begin
      op_val = (rnd % 6 == 0) ? csr_pkg::OP_ECALL : csr_pkg::OP_RW;
      issue(1'b0, op_val, addr_val, src_val, rnd);
    end
    else if (pick < 12)
      issue(1'b1, csr_pkg::OP_NONE, addr_val, src_val, rnd);
    else if (pick < 18)
      issue(1'b1, csr_pkg::OP_ECALL, addr_val, src_val, rnd);
    else if (pick < 24)
      issue(1'b1, csr_pkg::OP_MRET, addr_val, src_val, rnd);
    else
    begin
      case (rnd % 3)
        0:       op_val = csr_pkg::OP_RW;
        1:       op_val = csr_pkg::OP_RS;
        default: op_val = csr_pkg::OP_RC;
      endcase
      issue(1'b1, op_val, addr_val, src_val, $random(seed));
    end
  endtask

  initial
  begin
    #(timeout_ns);
    $display("Timeout: the run did not complete within %0d ns", timeout_ns);
    $display("Something failed");
    $fatal(1);
  end

  initial
  begin
    seed      = 32'h843363a9;
    exu_valid = 1'b0;
    op        = csr_pkg::OP_NONE;
    csr_addr  = 12'd0;
    src       = 32'd0;
    pc        = 32'd0;
    m_mstatus = 32'd0;
    m_mcause  = 32'd0;
    m_mepc    = 32'd0;
    m_mtvec   = 32'd0;
    @(posedge clk);
    while (rst)
      @(posedge clk);
    // reset values and id constants, read without writing
    for (int k = 0; k < 6; k++)
      issue(1'b1, csr_pkg::OP_RS, addr_by_index(k), 32'd0, 32'd0);
    for (int i = 0; i < num_instr; i++)
      issue_random();
    exu_valid <= 1'b0;
    $display("Everything OK");
    $finish;
  end

endmodule

/* src.f */
+incdir+common
common/csr_pkg.sv
common/csr_wr_if.sv
csr/csr_regfile.sv
csr/csr_alu.sv
rtl/csr_ctrl.sv
rtl/csr_unit_top.sv
tb/tb_clkgen.sv
tb/csr_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the csr unit testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module csr_unit_tb -f src.f -o csr_unit_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/csr_unit_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Everything OK" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
